// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary -j 0 --top-module tb_soc -f build.f -Mdir obj_dir -o tb_soc

run: compile
	./obj_dir/tb_soc | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_soc.sv
module tb_soc;

    localparam int ACK_TIMEOUT = 8;
    localparam int READY_TIMEOUT = 64;
    localparam int IRQ_TIMEOUT = 200;

    logic clk;
    logic arst_n_i;
    logic reset_req_i;
    logic bus_stb_i;
    logic bus_we_i;
    soc_pkg::bus_adr_t bus_adr_i;
    soc_pkg::bus_dat_t bus_wdat_i;
    soc_pkg::bus_dat_t bus_rdat_o;
    logic bus_ack_o;
    logic irq_o;
    logic ready_o;

    // stimulus table with one entry per bus access
    logic tab_we[$];
    soc_pkg::bus_adr_t tab_adr[$];
    soc_pkg::bus_dat_t tab_dat[$];
    soc_pkg::bus_dat_t tab_exp[$];
    string tab_name[$];

    soc_pkg::bus_dat_t ram_model [256];
    soc_pkg::lfsr_t lfsr_model;
    soc_pkg::ram_adr_t ra;
    logic [31:0] lcg_state;
    int i;
    int checks;
    int errors;
    int timeouts;

    soc_top i_dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .reset_req_i (reset_req_i),
        .bus_stb_i   (bus_stb_i),
        .bus_we_i    (bus_we_i),
        .bus_adr_i   (bus_adr_i),
        .bus_wdat_i  (bus_wdat_i),
        .bus_rdat_o  (bus_rdat_o),
        .bus_ack_o   (bus_ack_o),
        .irq_o       (irq_o),
        .ready_o     (ready_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // galois step shifts right and folds the taps in on a one
    function automatic soc_pkg::lfsr_t lfsr_next(input soc_pkg::lfsr_t s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic soc_pkg::lfsr_t seed_with(input soc_pkg::lfsr_t s, input logic hi,
                                                 input soc_pkg::bus_dat_t b);
        soc_pkg::lfsr_t n;
        n = hi ? {b, s[7:0]} : {s[15:8], b};
        return (n == 16'h0000) ? 16'hACE1 : n;
    endfunction

    task automatic check_dat(input string name, input soc_pkg::bus_dat_t exp,
                             input soc_pkg::bus_dat_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic add_entry(input logic we, input soc_pkg::bus_adr_t adr,
                             input soc_pkg::bus_dat_t dat, input soc_pkg::bus_dat_t exp,
                             input string name);
        tab_we.push_back(we);
        tab_adr.push_back(adr);
        tab_dat.push_back(dat);
        tab_exp.push_back(exp);
        tab_name.push_back(name);
    endtask

    task automatic bus_access(input logic we, input soc_pkg::bus_adr_t adr,
                              input soc_pkg::bus_dat_t wdat, output soc_pkg::bus_dat_t rdat);
        int n;
        @(negedge clk);
        bus_stb_i = 1'b1;
        bus_we_i = we;
        bus_adr_i = adr;
        bus_wdat_i = wdat;
        rdat = 8'h00;
        n = 0;
        @(negedge clk);
        while (bus_ack_o !== 1'b1 && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (bus_ack_o === 1'b1) begin
            rdat = bus_rdat_o;
        end else begin
            timeouts++;
            $display("timeout: no acknowledge for address %h", adr);
        end
        bus_stb_i = 1'b0;
    endtask

    task automatic run_table();
        soc_pkg::bus_dat_t rdat;
        int k;
        for (k = 0; k < tab_adr.size(); k++) begin
            bus_access(tab_we[k], tab_adr[k], tab_dat[k], rdat);
            if (!tab_we[k]) begin
                check_dat(tab_name[k], tab_exp[k], rdat);
            end
        end
        tab_we.delete();
        tab_adr.delete();
        tab_dat.delete();
        tab_exp.delete();
        tab_name.delete();
    endtask

    // quiet also checks that the bus and irq stay idle meanwhile
    task automatic wait_ready(input logic level, input logic quiet, input string what);
        int n;
        n = 0;
        while (ready_o !== level && n < READY_TIMEOUT) begin
            if (quiet) begin
                check_bit("ack low before ready", 1'b0, bus_ack_o);
                check_bit("irq low before ready", 1'b0, irq_o);
            end
            @(negedge clk);
            n++;
        end
        if (ready_o !== level) begin
            timeouts++;
            $display("timeout: ready_o did not %s", what);
        end
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        while (irq_o !== 1'b1 && n < IRQ_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (irq_o !== 1'b1) begin
            timeouts++;
            $display("timeout: irq_o did not rise after the timer was enabled");
        end
    endtask

    initial begin
        arst_n_i = 1'b0;
        reset_req_i = 1'b0;
        bus_stb_i = 1'b0;
        bus_we_i = 1'b0;
        bus_adr_i = 16'h0000;
        bus_wdat_i = 8'h00;
        lcg_state = 32'd50;
        lfsr_model = 16'hACE1;
        checks = 0;
        errors = 0;
        timeouts = 0;
        repeat (2) @(negedge clk);
        arst_n_i = 1'b1;
        wait_ready(1'b1, 1'b1, "rise after power-up reset");

        // ram at scattered addresses
        for (i = 0; i < 8; i++) begin
            ra = soc_pkg::ram_adr_t'(i * 37 + 5);
            lcg_state = lcg(lcg_state);
            ram_model[ra] = lcg_state[23:16];
            add_entry(1'b1, {8'h00, ra}, lcg_state[23:16], 8'h00, "ram write");
        end
        for (i = 0; i < 8; i++) begin
            ra = soc_pkg::ram_adr_t'(i * 37 + 5);
            add_entry(1'b0, {8'h00, ra}, 8'h00, ram_model[ra], $sformatf("ram read %h", ra));
        end
        run_table();

        // holes in the map
        // the write aliases ram byte 5 in its low bits
        add_entry(1'b0, 16'h8000, 8'h00, 8'hFF, "unmapped read 8000");
        add_entry(1'b0, 16'hFD04, 8'h00, 8'hFF, "unmapped read fd04");
        add_entry(1'b0, 16'hFE02, 8'h00, 8'hFF, "unmapped read fe02");
        add_entry(1'b1, 16'h8005, ~ram_model[5], 8'h00, "unmapped write");
        add_entry(1'b0, 16'h0005, 8'h00, ram_model[5], "ram after unmapped write");
        run_table();

        // timer
        add_entry(1'b1, 16'hFD00, 8'd20, 8'h00, "reload lo write");
        add_entry(1'b1, 16'hFD01, 8'd0, 8'h00, "reload hi write");
        add_entry(1'b1, 16'hFD02, 8'h03, 8'h00, "ctrl enable");
        run_table();
        wait_irq();
        // stop counting so no new expiry races the clear
        add_entry(1'b1, 16'hFD02, 8'h02, 8'h00, "ctrl stop");
        add_entry(1'b0, 16'hFD03, 8'h00, 8'h01, "status after expiry");
        add_entry(1'b1, 16'hFD03, 8'h01, 8'h00, "status clear");
        run_table();
        check_bit("irq after clear", 1'b0, irq_o);
        add_entry(1'b0, 16'hFD03, 8'h00, 8'h00, "status after clear");
        add_entry(1'b0, 16'hFD00, 8'h00, 8'd20, "reload lo read");
        add_entry(1'b0, 16'hFD01, 8'h00, 8'd0, "reload hi read");
        add_entry(1'b0, 16'hFD02, 8'h00, 8'h02, "ctrl read");
        run_table();

        // prng
        lfsr_model = seed_with(lfsr_model, 1'b0, 8'h34);
        add_entry(1'b1, 16'hFE00, 8'h34, 8'h00, "seed lo");
        lfsr_model = seed_with(lfsr_model, 1'b1, 8'h12);
        add_entry(1'b1, 16'hFE01, 8'h12, 8'h00, "seed hi");
        add_entry(1'b0, 16'hFE01, 8'h00, lfsr_model[15:8], "prng high byte");
        for (i = 0; i < 5; i++) begin
            add_entry(1'b0, 16'hFE00, 8'h00, lfsr_model[7:0], $sformatf("prng read %0d", i));
            lfsr_model = lfsr_next(lfsr_model);
        end
        lfsr_model = seed_with(lfsr_model, 1'b0, 8'h00);
        add_entry(1'b1, 16'hFE00, 8'h00, 8'h00, "zero seed lo");
        lfsr_model = seed_with(lfsr_model, 1'b1, 8'h00);
        add_entry(1'b1, 16'hFE01, 8'h00, 8'h00, "zero seed hi");
        for (i = 0; i < 3; i++) begin
            add_entry(1'b0, 16'hFE00, 8'h00, lfsr_model[7:0], $sformatf("reseed read %0d", i));
            lfsr_model = lfsr_next(lfsr_model);
        end
        run_table();

        // external reset request
        add_entry(1'b1, 16'hFD02, 8'h03, 8'h00, "ctrl enable again");
        run_table();
        // irq high going in, so the reset has something to clear
        wait_irq();
        @(negedge clk);
        reset_req_i = 1'b1;
        wait_ready(1'b0, 1'b0, "fall on reset request");
        @(negedge clk);
        reset_req_i = 1'b0;
        wait_ready(1'b1, 1'b0, "rise after reset request");
        check_bit("ready after reset request", 1'b1, ready_o);
        check_bit("irq after reset request", 1'b0, irq_o);
        add_entry(1'b0, 16'hFD02, 8'h00, 8'h00, "ctrl after reset request");
        run_table();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: build.f
rtl/soc_pkg.sv
rtl/reset_sequencer.sv
rtl/bus_decoder.sv
rtl/bram_wb8.sv
rtl/timer_wb8.sv
rtl/prng_wb8.sv
rtl/soc_top.sv
bench/tb_soc.sv

// File: rtl/bram_wb8.sv
module bram_wb8 (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              sys_rst_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  soc_pkg::ram_adr_t adr_i,
    input  soc_pkg::bus_dat_t wdat_i,
    output soc_pkg::bus_dat_t rdat_o,
    output logic              ack_o
);

    soc_pkg::bus_dat_t mem [2**soc_pkg::RAM_ADR_W];
    logic req;

    assign req = stb_i && !ack_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else if (sys_rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req;
        end
    end

    // array and read register map onto block RAM
    always_ff @(posedge clk) begin
        if (req && we_i) begin
            mem[adr_i] <= wdat_i;
        end
        if (req && !we_i) begin
            rdat_o <= mem[adr_i];
        end
    end

endmodule

// File: rtl/bus_decoder.sv
module bus_decoder (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              sys_rst_i,
    input  logic              bus_stb_i,
    input  soc_pkg::bus_adr_t bus_adr_i,
    output logic              ram_stb_o,
    output logic              timer_stb_o,
    output logic              prng_stb_o,
    input  logic              ram_ack_i,
    input  soc_pkg::bus_dat_t ram_rdat_i,
    input  logic              timer_ack_i,
    input  soc_pkg::bus_dat_t timer_rdat_i,
    input  logic              prng_ack_i,
    input  soc_pkg::bus_dat_t prng_rdat_i,
    output logic              bus_ack_o,
    output soc_pkg::bus_dat_t bus_rdat_o
);

    logic ram_sel;
    logic timer_sel;
    logic prng_sel;
    logic unm_sel;
    logic unm_ack_q;

    // upper address bits select the slave
    assign ram_sel = bus_adr_i[soc_pkg::BUS_ADR_W-1:soc_pkg::RAM_ADR_W]
        == soc_pkg::RAM_BASE[soc_pkg::BUS_ADR_W-1:soc_pkg::RAM_ADR_W];
    assign timer_sel = bus_adr_i[soc_pkg::BUS_ADR_W-1:soc_pkg::TIMER_ADR_W]
        == soc_pkg::TIMER_BASE[soc_pkg::BUS_ADR_W-1:soc_pkg::TIMER_ADR_W];
    assign prng_sel = bus_adr_i[soc_pkg::BUS_ADR_W-1:soc_pkg::PRNG_ADR_W]
        == soc_pkg::PRNG_BASE[soc_pkg::BUS_ADR_W-1:soc_pkg::PRNG_ADR_W];
    assign unm_sel = !(ram_sel || timer_sel || prng_sel);

    assign ram_stb_o = bus_stb_i && ram_sel;
    assign timer_stb_o = bus_stb_i && timer_sel;
    assign prng_stb_o = bus_stb_i && prng_sel;

    // local responder so the master never hangs on a hole in the map
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            unm_ack_q <= 1'b0;
        end else if (sys_rst_i) begin
            unm_ack_q <= 1'b0;
        end else begin
            unm_ack_q <= bus_stb_i && unm_sel && !unm_ack_q;
        end
    end

    always_comb begin
        if (ram_sel) begin
            bus_ack_o = ram_ack_i;
            bus_rdat_o = ram_rdat_i;
        end else if (timer_sel) begin
            bus_ack_o = timer_ack_i;
            bus_rdat_o = timer_rdat_i;
        end else if (prng_sel) begin
            bus_ack_o = prng_ack_i;
            bus_rdat_o = prng_rdat_i;
        end else begin
            bus_ack_o = unm_ack_q;
            bus_rdat_o = soc_pkg::UNMAPPED_DAT;
        end
    end

endmodule

// File: rtl/prng_wb8.sv
module prng_wb8 (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic                               sys_rst_i,
    input  logic                               stb_i,
    input  logic                               we_i,
    input  logic [soc_pkg::PRNG_ADR_W-1:0]     adr_i,
    input  soc_pkg::bus_dat_t                  wdat_i,
    output soc_pkg::bus_dat_t                  rdat_o,
    output logic                               ack_o
);

    soc_pkg::lfsr_t lfsr_q;
    soc_pkg::lfsr_t seed;
    soc_pkg::lfsr_t step;
    logic req;

    assign req = stb_i && !ack_o;

    // new seed with one byte replaced
    assign seed = adr_i[0] ? {wdat_i, lfsr_q[7:0]} : {lfsr_q[15:8], wdat_i};

    // galois step, right shift
    assign step = lfsr_q[0] ? ((lfsr_q >> 1) ^ soc_pkg::LFSR_TAPS) : (lfsr_q >> 1);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lfsr_q <= soc_pkg::LFSR_RESET_SEED;
            ack_o <= 1'b0;
        end else if (sys_rst_i) begin
            lfsr_q <= soc_pkg::LFSR_RESET_SEED;
            ack_o <= 1'b0;
        end else begin
            ack_o <= req;
            if (req && we_i) begin
                // all-zero state would lock up
                lfsr_q <= (seed == '0) ? soc_pkg::LFSR_RESET_SEED : seed;
            end else if (req && !adr_i[0]) begin
                lfsr_q <= step;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !we_i) begin
            rdat_o <= adr_i[0] ? lfsr_q[15:8] : lfsr_q[7:0];
        end
    end

endmodule

// File: rtl/reset_sequencer.sv
module reset_sequencer (
    input  logic clk,
    input  logic arst_n_i,
    input  logic reset_req_i,
    output logic sys_rst_o,
    output logic ready_o
);

    soc_pkg::rst_state_t state_q;
    soc_pkg::rst_state_t state_d;
    soc_pkg::settle_cnt_t cnt_q;
    soc_pkg::settle_cnt_t cnt_d;

    always_comb begin
        state_d = state_q;
        cnt_d = cnt_q;
        if (reset_req_i) begin
            // request overrides everything, counter restarts on release
            state_d = soc_pkg::RST_HOLD;
            cnt_d = '0;
        end else begin
            case (state_q)
                soc_pkg::RST_HOLD: begin
                    state_d = soc_pkg::RST_SETTLE;
                    cnt_d = '0;
                end
                soc_pkg::RST_SETTLE: begin
                    if (cnt_q == soc_pkg::settle_cnt_t'(soc_pkg::SETTLE_CYCLES - 1)) begin
                        state_d = soc_pkg::RST_RUN;
                    end else begin
                        cnt_d = cnt_q + 1'b1;
                    end
                end
                soc_pkg::RST_RUN: begin
                    state_d = soc_pkg::RST_RUN;
                end
                default: begin
                    state_d = soc_pkg::RST_SETTLE;
                    cnt_d = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= soc_pkg::RST_SETTLE;
            cnt_q <= '0;
            sys_rst_o <= 1'b1;
            ready_o <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q <= cnt_d;
            sys_rst_o <= (state_d != soc_pkg::RST_RUN);
            ready_o <= (state_d == soc_pkg::RST_RUN);
        end
    end

endmodule

// File: rtl/soc_pkg.sv
package soc_pkg;

    // bus and slave widths
    localparam int BUS_ADR_W = 16;
    localparam int BUS_DAT_W = 8;
    localparam int RAM_ADR_W = 8;
    localparam int TIMER_ADR_W = 2;
    localparam int PRNG_ADR_W = 1;

    typedef logic [BUS_ADR_W-1:0] bus_adr_t;
    typedef logic [BUS_DAT_W-1:0] bus_dat_t;
    typedef logic [RAM_ADR_W-1:0] ram_adr_t;
    typedef logic [15:0] timer_cnt_t;
    typedef logic [15:0] lfsr_t;

    // address map
    localparam bus_adr_t RAM_BASE = 16'h0000;
    localparam bus_adr_t TIMER_BASE = 16'hFD00;
    localparam bus_adr_t PRNG_BASE = 16'hFE00;
    localparam bus_dat_t UNMAPPED_DAT = 8'hFF;

    localparam logic [TIMER_ADR_W-1:0] TIMER_REG_RELOAD_LO = 2'd0;
    localparam logic [TIMER_ADR_W-1:0] TIMER_REG_RELOAD_HI = 2'd1;
    localparam logic [TIMER_ADR_W-1:0] TIMER_REG_CTRL = 2'd2;
    localparam logic [TIMER_ADR_W-1:0] TIMER_REG_STATUS = 2'd3;

    localparam lfsr_t LFSR_TAPS = 16'hB400;
    localparam lfsr_t LFSR_RESET_SEED = 16'hACE1;

    localparam int SETTLE_CYCLES = 16;
    typedef logic [$clog2(SETTLE_CYCLES)-1:0] settle_cnt_t;

    typedef enum logic [1:0] {RST_HOLD, RST_SETTLE, RST_RUN} rst_state_t;

endpackage

// File: rtl/soc_top.sv
module soc_top (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              reset_req_i,
    input  logic              bus_stb_i,
    input  logic              bus_we_i,
    input  soc_pkg::bus_adr_t bus_adr_i,
    input  soc_pkg::bus_dat_t bus_wdat_i,
    output soc_pkg::bus_dat_t bus_rdat_o,
    output logic              bus_ack_o,
    output logic              irq_o,
    output logic              ready_o
);

    logic sys_rst;
    logic ram_stb;
    logic ram_ack;
    logic timer_stb;
    logic timer_ack;
    logic prng_stb;
    logic prng_ack;
    soc_pkg::bus_dat_t ram_rdat;
    soc_pkg::bus_dat_t timer_rdat;
    soc_pkg::bus_dat_t prng_rdat;

    reset_sequencer i_reset_sequencer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .reset_req_i (reset_req_i),
        .sys_rst_o   (sys_rst),
        .ready_o     (ready_o)
    );

    bus_decoder i_bus_decoder (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .sys_rst_i    (sys_rst),
        .bus_stb_i    (bus_stb_i),
        .bus_adr_i    (bus_adr_i),
        .ram_stb_o    (ram_stb),
        .timer_stb_o  (timer_stb),
        .prng_stb_o   (prng_stb),
        .ram_ack_i    (ram_ack),
        .ram_rdat_i   (ram_rdat),
        .timer_ack_i  (timer_ack),
        .timer_rdat_i (timer_rdat),
        .prng_ack_i   (prng_ack),
        .prng_rdat_i  (prng_rdat),
        .bus_ack_o    (bus_ack_o),
        .bus_rdat_o   (bus_rdat_o)
    );

    bram_wb8 i_bram (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .sys_rst_i (sys_rst),
        .stb_i     (ram_stb),
        .we_i      (bus_we_i),
        .adr_i     (bus_adr_i[soc_pkg::RAM_ADR_W-1:0]),
        .wdat_i    (bus_wdat_i),
        .rdat_o    (ram_rdat),
        .ack_o     (ram_ack)
    );

    timer_wb8 i_timer (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .sys_rst_i (sys_rst),
        .stb_i     (timer_stb),
        .we_i      (bus_we_i),
        .adr_i     (bus_adr_i[soc_pkg::TIMER_ADR_W-1:0]),
        .wdat_i    (bus_wdat_i),
        .rdat_o    (timer_rdat),
        .ack_o     (timer_ack),
        .irq_o     (irq_o)
    );

    prng_wb8 i_prng (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .sys_rst_i (sys_rst),
        .stb_i     (prng_stb),
        .we_i      (bus_we_i),
        .adr_i     (bus_adr_i[soc_pkg::PRNG_ADR_W-1:0]),
        .wdat_i    (bus_wdat_i),
        .rdat_o    (prng_rdat),
        .ack_o     (prng_ack)
    );

endmodule

// File: rtl/timer_wb8.sv
module timer_wb8 (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                sys_rst_i,
    input  logic                                stb_i,
    input  logic                                we_i,
    input  logic [soc_pkg::TIMER_ADR_W-1:0]     adr_i,
    input  soc_pkg::bus_dat_t                   wdat_i,
    output soc_pkg::bus_dat_t                   rdat_o,
    output logic                                ack_o,
    output logic                                irq_o
);

    soc_pkg::timer_cnt_t reload_q;
    soc_pkg::timer_cnt_t cnt_q;
    soc_pkg::bus_dat_t rd_dat;
    logic en_q;
    logic irq_en_q;
    logic expired_q;
    logic req;

    // first cycle of a strobe only
    assign req = stb_i && !ack_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reload_q <= '0;
            cnt_q <= '0;
            en_q <= 1'b0;
            irq_en_q <= 1'b0;
            expired_q <= 1'b0;
            ack_o <= 1'b0;
        end else if (sys_rst_i) begin
            reload_q <= '0;
            cnt_q <= '0;
            en_q <= 1'b0;
            irq_en_q <= 1'b0;
            expired_q <= 1'b0;
            ack_o <= 1'b0;
        end else begin
            ack_o <= req;
            if (req && we_i) begin
                case (adr_i)
                    soc_pkg::TIMER_REG_RELOAD_LO: reload_q[7:0] <= wdat_i;
                    soc_pkg::TIMER_REG_RELOAD_HI: reload_q[15:8] <= wdat_i;
                    soc_pkg::TIMER_REG_CTRL: begin
                        en_q <= wdat_i[0];
                        irq_en_q <= wdat_i[1];
                    end
                    default: begin
                        if (wdat_i[0]) begin
                            expired_q <= 1'b0;
                        end
                    end
                endcase
            end
            // an expiry in the same cycle as a clear still sets the flag
            if (en_q) begin
                if (cnt_q == '0) begin
                    cnt_q <= reload_q;
                    expired_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (adr_i)
            soc_pkg::TIMER_REG_RELOAD_LO: rd_dat = reload_q[7:0];
            soc_pkg::TIMER_REG_RELOAD_HI: rd_dat = reload_q[15:8];
            soc_pkg::TIMER_REG_CTRL: rd_dat = {6'b0, irq_en_q, en_q};
            default: rd_dat = {7'b0, expired_q};
        endcase
    end

    always_ff @(posedge clk) begin
        if (req && !we_i) begin
            rdat_o <= rd_dat;
        end
    end

    assign irq_o = expired_q && irq_en_q;

endmodule
